// File: mc_alu_sub.f
logic/alu_op_pkg.sv
logic/alu_flow_pkg.sv
logic/issue_port.sv
logic/issue_arbiter.sv
logic/mc_alu.sv
logic/mc_alu_sub_top.sv
verif/mc_alu_sub_chk.sv
verif/tb_mc_alu_sub.sv

// File: Bender.yml
package:
  name: mc_alu_sub

sources:
  # Packages first, then the RTL from the leaves up to the top level
  - logic/alu_op_pkg.sv
  - logic/alu_flow_pkg.sv
  - logic/issue_port.sv
  - logic/issue_arbiter.sv
  - logic/mc_alu.sv
  - logic/mc_alu_sub_top.sv
  # Bound checker and testbench, only for simulation
  - target: verif
    files:
      - verif/mc_alu_sub_chk.sv
      - verif/tb_mc_alu_sub.sv

// File: verif/tb_mc_alu_sub.sv
`timescale 1ns/10ps

module tb_mc_alu_sub;
	import alu_op_pkg::*, alu_flow_pkg::*;

	// One operation as the source sends it
	typedef struct packed {
		alu_op_e code;
		value_t  a;
		value_t  b;
		value_t  c;
		value_t  imm;
		tag_t    tag;
	} op_t;

	// The timeout is derived from these test sizes
	localparam int N_CORNER    = 4;
	localparam int N_LOAD      = 20;
	localparam int N_BP        = 8;
	localparam int HOLD_CYC    = 20;
	localparam int N_OPS       = 2 * (6 + N_CORNER) + 2 * N_LOAD + 2 * N_BP;
	localparam int TIMEOUT_CYC = 40 * N_OPS + 200;

	logic       clk;
	logic       rst_n;
	logic [1:0] op_valid;
	alu_op_e    op_code [2];
	value_t     op_a    [2];
	value_t     op_b    [2];
	value_t     op_c    [2];
	value_t     op_imm  [2];
	tag_t       op_tag  [2];
	logic [1:0] op_credit;
	logic [1:0] res_valid;
	value_t     res_data [2];
	tag_t       res_tag  [2];
	logic [1:0] res_credit;

	// Scoreboard state with one entry per port
	op_t        send_q [2][$];
	op_t        exp_q  [2][$];
	int         src_cred [2];
	int         owed [2];
	int         sent [2];
	int         got  [2];
	tag_t       next_tag [2];
	logic [1:0] hold;

	int         pass_cnt = 0;
	int         fail_cnt = 0;
	int         cycle_cnt = 0;
	int         test_fails;
	string      test_name;

	mc_alu_sub_top UUT (
		.clk(clk), .rst_n_i(rst_n),
		.op_valid_0_i(op_valid[0]), .op_code_0_i(op_code[0]), .op_a_0_i(op_a[0]),
		.op_b_0_i(op_b[0]), .op_c_0_i(op_c[0]), .op_imm_0_i(op_imm[0]),
		.op_tag_0_i(op_tag[0]), .op_credit_0_o(op_credit[0]),
		.res_valid_0_o(res_valid[0]), .res_data_0_o(res_data[0]),
		.res_tag_0_o(res_tag[0]), .res_credit_0_i(res_credit[0]),
		.op_valid_1_i(op_valid[1]), .op_code_1_i(op_code[1]), .op_a_1_i(op_a[1]),
		.op_b_1_i(op_b[1]), .op_c_1_i(op_c[1]), .op_imm_1_i(op_imm[1]),
		.op_tag_1_i(op_tag[1]), .op_credit_1_o(op_credit[1]),
		.res_valid_1_o(res_valid[1]), .res_data_1_o(res_data[1]),
		.res_tag_1_o(res_tag[1]), .res_credit_1_i(res_credit[1])
	);

	// Request lines are internal to the top, so they are wired by name
	bind mc_alu_sub_top mc_alu_sub_chk u_chk (
		.*,
		.issue_req_0_i(issue_req_0),
		.issue_req_1_i(issue_req_1)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==================================================
	// Reference arithmetic and helpers
	// ==================================================

	// Signed product of a and the multiplier
	// The fused forms wrap to DATA_W bits
	function automatic value_t expect_result(op_t op);
		longint sa;
		longint sm;
		longint prod;
		value_t lo;
		sa = longint'($signed(op.a));
		sm = (op.code == OP_MULI) ? longint'($signed(op.imm)) : longint'($signed(op.b));
		prod = sa * sm;
		lo = prod[DATA_W-1:0];
		case (op.code)
			OP_MULH:  return prod[2*DATA_W-1:DATA_W];
			OP_MADD:  return lo + op.c;
			OP_MSUB:  return lo - op.c;
			OP_NMADD: return op.c - lo;
			default:  return lo;
		endcase
	endfunction

	function automatic int failures();
		return fail_cnt + UUT.u_chk.err_cnt;
	endfunction

	task automatic queue_op(input int p, input alu_op_e code, input value_t a,
			input value_t b, input value_t c, input value_t imm);
		op_t op;
		op = '{code: code, a: a, b: b, c: c, imm: imm, tag: next_tag[p]};
		next_tag[p]++;
		send_q[p].push_back(op);
	endtask

	task automatic queue_random(input int p, input alu_op_e code);
		queue_op(p, code, $urandom, $urandom, $urandom, $urandom);
	endtask

	// Returns once every queued operation has come back and been credited
	task automatic wait_drained();
		while (send_q[0].size() != 0 || send_q[1].size() != 0 || exp_q[0].size() != 0
				|| exp_q[1].size() != 0 || owed[0] != 0 || owed[1] != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_fails = failures();
	endtask

	task automatic end_test();
		if (failures() == test_fails) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d failing checks", test_name, failures() - test_fails);
		end
	endtask

	// ==================================================
	// Sources and consumers driven on the falling edge
	// ==================================================

	always @(negedge clk) begin : drive_and_check
		op_t    cur;
		value_t want;
		if (!rst_n) begin
			assert (op_credit == 2'b00 && res_valid == 2'b00) pass_cnt++;
			else begin
				$display("credit or result output active while reset is held");
				fail_cnt++;
			end
		end else begin
			for (int p = 0; p < 2; p++) begin
				// A credit pulse seen in this cycle can be spent at once
				if (op_credit[p]) begin
					src_cred[p]++;
				end
				op_valid[p] = 1'b0;
				if (src_cred[p] > 0 && send_q[p].size() != 0) begin
					cur = send_q[p].pop_front();
					op_valid[p] = 1'b1;
					op_code[p]  = cur.code;
					op_a[p]     = cur.a;
					op_b[p]     = cur.b;
					op_c[p]     = cur.c;
					op_imm[p]   = cur.imm;
					op_tag[p]   = cur.tag;
					exp_q[p].push_back(cur);
					src_cred[p]--;
					sent[p]++;
				end
				// Results of a port must come back in the order they were sent
				if (res_valid[p]) begin
					got[p]++;
					owed[p]++;
					if (exp_q[p].size() == 0) begin
						$display("port %0d returned a result with nothing outstanding in %s",
							p, test_name);
						fail_cnt++;
					end else begin
						cur = exp_q[p].pop_front();
						want = expect_result(cur);
						assert (res_data[p] == want) pass_cnt++;
						else begin
							$display("mismatch %s port %0d data expected %h actual %h",
								test_name, p, want, res_data[p]);
							fail_cnt++;
						end
						assert (res_tag[p] == cur.tag) pass_cnt++;
						else begin
							$display("mismatch %s port %0d tag expected %0d actual %0d",
								test_name, p, cur.tag, res_tag[p]);
							fail_cnt++;
						end
					end
				end
				// The consumer hands one slot back per cycle unless it is holding
				res_credit[p] = 1'b0;
				if (!hold[p] && owed[p] > 0) begin
					res_credit[p] = 1'b1;
					owed[p]--;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYC) begin
			$display("timeout after %0d cycles with results still outstanding", cycle_cnt);
			$display("Verification failed");
			$finish;
		end
	end

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin : main
		int base;
		void'($urandom(87));
		rst_n = 1'b0;
		op_valid = 2'b00;
		res_credit = 2'b00;
		hold = 2'b00;
		for (int p = 0; p < 2; p++) begin
			op_code[p] = OP_MUL;
			op_a[p] = '0;
			op_b[p] = '0;
			op_c[p] = '0;
			op_imm[p] = '0;
			op_tag[p] = '0;
			src_cred[p] = QUEUE_DEPTH;
			owed[p] = 0;
			sent[p] = 0;
			got[p] = 0;
			next_tag[p] = '0;
		end

		begin_test("reset");
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);
		end_test();

		// Every opcode on both ports, then the signed corners of the high product
		begin_test("opcodes");
		for (int p = 0; p < 2; p++) begin
			for (int k = 0; k < 6; k++) begin
				queue_random(p, alu_op_e'(k));
			end
			queue_op(p, OP_MULH, 32'h8000_0000, 32'h8000_0000, '0, '0);
			queue_op(p, OP_MULH, 32'h8000_0000, 32'hFFFF_FFFF, '0, '0);
			queue_op(p, OP_MULH, 32'h7FFF_FFFF, 32'h8000_0000, '0, '0);
			queue_op(p, OP_MULH, 32'hFFFF_FFFF, 32'hFFFF_FFFF, '0, '0);
		end
		wait_drained();
		end_test();

		begin_test("ordering_load");
		for (int i = 0; i < N_LOAD; i++) begin
			queue_random(0, alu_op_e'($urandom_range(5, 0)));
			queue_random(1, alu_op_e'($urandom_range(5, 0)));
		end
		wait_drained();
		end_test();

		// Each consumer in turn withholds its slots until its port has stalled
		begin_test("backpressure");
		for (int p = 0; p < 2; p++) begin
			base = got[p];
			hold[p] = 1'b1;
			for (int i = 0; i < N_BP; i++) begin
				queue_random(p, alu_op_e'($urandom_range(5, 0)));
			end
			while (got[p] - base < int'(RES_CREDITS)) begin
				@(negedge clk);
			end
			repeat (HOLD_CYC) @(negedge clk);
			assert (got[p] - base == int'(RES_CREDITS)) pass_cnt++;
			else begin
				$display("mismatch backpressure port %0d results expected %0d actual %0d",
					p, RES_CREDITS, got[p] - base);
				fail_cnt++;
			end
			hold[p] = 1'b0;
			wait_drained();
			assert (got[p] - base == N_BP) pass_cnt++;
			else begin
				$display("mismatch backpressure port %0d total expected %0d actual %0d",
					p, N_BP, got[p] - base);
				fail_cnt++;
			end
		end
		end_test();

		begin_test("totals");
		for (int p = 0; p < 2; p++) begin
			assert (got[p] == sent[p]) pass_cnt++;
			else begin
				$display("mismatch totals port %0d expected %0d actual %0d", p, sent[p], got[p]);
				fail_cnt++;
			end
		end
		end_test();

		$display("checks passed: %0d, failed: %0d", pass_cnt, failures());
		if (failures() == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: verif/mc_alu_sub_chk.sv
`timescale 1ns/10ps

module mc_alu_sub_chk
	import alu_flow_pkg::*;
(
	input  logic clk,
	input  logic rst_n_i,
	input  logic op_valid_0_i,
	input  logic op_valid_1_i,
	input  logic op_credit_0_o,
	input  logic op_credit_1_o,
	input  logic res_valid_0_o,
	input  logic res_valid_1_o,
	input  logic res_credit_0_i,
	input  logic res_credit_1_i,
	input  logic issue_req_0_i,
	input  logic issue_req_1_i
);

	// Number of failed assertions seen by the testbench
	int err_cnt = 0;

	// Both ports gathered into vectors so one block covers each of them
	logic [1:0] op_valid;
	logic [1:0] op_credit;
	logic [1:0] res_valid;
	logic [1:0] res_credit;
	logic [1:0] issue_req;

	assign op_valid   = {op_valid_1_i, op_valid_0_i};
	assign op_credit  = {op_credit_1_o, op_credit_0_o};
	assign res_valid  = {res_valid_1_o, res_valid_0_o};
	assign res_credit = {res_credit_1_i, res_credit_0_i};
	assign issue_req  = {issue_req_1_i, issue_req_0_i};

	for (genvar p = 0; p < 2; p++) begin : g_port

		// Issue credits the source holds before any pulse of the current cycle
		credit_cnt_t src_cred_q;
		// Result slots the consumer has granted and that are not yet used
		credit_cnt_t res_cred_q;

		always_ff @(posedge clk or negedge rst_n_i) begin
			if (!rst_n_i) begin
				src_cred_q <= credit_cnt_t'(QUEUE_DEPTH);
				res_cred_q <= credit_cnt_t'(RES_CREDITS);
			end else begin
				src_cred_q <= src_cred_q + credit_cnt_t'(op_credit[p])
					- credit_cnt_t'(op_valid[p]);
				res_cred_q <= res_cred_q - credit_cnt_t'(res_valid[p])
					+ credit_cnt_t'(res_credit[p]);
			end
		end

		// ==================================================
		// Reset and credit pools
		// ==================================================

		// Quiet outputs while reset is held and in the first cycle after it
		a_reset_quiet: assert property (@(posedge clk)
			(!rst_n_i || $rose(rst_n_i)) |-> (!op_credit[p] && !res_valid[p]))
			else begin
				$error("port %0d drives a credit or a result around reset", p);
				err_cnt++;
			end

		// The port never hands back more slots than its queue has
		a_src_cred_max: assert property (@(posedge clk) disable iff (!rst_n_i)
			src_cred_q <= credit_cnt_t'(QUEUE_DEPTH))
			else begin
				$error("port %0d returned more issue credits than queue slots", p);
				err_cnt++;
			end

		// Each delivered result must be covered by a result credit
		a_res_cred: assert property (@(posedge clk) disable iff (!rst_n_i)
			res_valid[p] |-> res_cred_q != '0)
			else begin
				$error("port %0d delivered a result without a result credit", p);
				err_cnt++;
			end

		// ==================================================
		// Latency and fairness
		// ==================================================

		a_lat_fwd: assert property (@(posedge clk) disable iff (!rst_n_i)
			op_credit[p] |-> ##(ALU_LAT-1) res_valid[p])
			else begin
				$error("port %0d result missing after an issue credit", p);
				err_cnt++;
			end

		a_lat_back: assert property (@(posedge clk) disable iff (!rst_n_i)
			res_valid[p] |-> $past(op_credit[p], ALU_LAT-1))
			else begin
				$error("port %0d result without a matching issue credit", p);
				err_cnt++;
			end

		// A waiting request loses at most one contested cycle to the other port
		a_progress: assert property (@(posedge clk) disable iff (!rst_n_i)
			issue_req[p] |-> ##[1:2] op_credit[p])
			else begin
				$error("port %0d kept a request without issuing", p);
				err_cnt++;
			end
	end

endmodule

// File: logic/mc_alu_sub_top.sv
`timescale 1ns/10ps

module mc_alu_sub_top
	import alu_op_pkg::*, alu_flow_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n_i,
	// Port 0 upstream
	input  logic    op_valid_0_i,
	input  alu_op_e op_code_0_i,
	input  value_t  op_a_0_i,
	input  value_t  op_b_0_i,
	input  value_t  op_c_0_i,
	input  value_t  op_imm_0_i,
	input  tag_t    op_tag_0_i,
	output logic    op_credit_0_o,
	// Port 0 downstream
	output logic    res_valid_0_o,
	output value_t  res_data_0_o,
	output tag_t    res_tag_0_o,
	input  logic    res_credit_0_i,
	// Port 1 upstream
	input  logic    op_valid_1_i,
	input  alu_op_e op_code_1_i,
	input  value_t  op_a_1_i,
	input  value_t  op_b_1_i,
	input  value_t  op_c_1_i,
	input  value_t  op_imm_1_i,
	input  tag_t    op_tag_1_i,
	output logic    op_credit_1_o,
	// Port 1 downstream
	output logic    res_valid_1_o,
	output value_t  res_data_1_o,
	output tag_t    res_tag_1_o,
	input  logic    res_credit_1_i
);

	// Requests and grants between the ports and the arbiter
	logic       issue_req_0;
	logic       issue_req_1;
	logic [1:0] gnt;
	port_id_t   alu_sel;

	// Head operands of each port
	alu_op_e    issue_code_0;
	value_t     issue_a_0;
	value_t     issue_b_0;
	value_t     issue_c_0;
	value_t     issue_imm_0;
	tag_t       issue_tag_0;
	alu_op_e    issue_code_1;
	value_t     issue_a_1;
	value_t     issue_b_1;
	value_t     issue_c_1;
	value_t     issue_imm_1;
	tag_t       issue_tag_1;

	// Shared result bus seen by both ports
	logic       rb_valid;
	value_t     rb_data;
	tag_t       rb_tag;
	port_id_t   rb_port;

	issue_port #(
		.PORT_ID(1'b0)
	) u_port0 (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.op_valid_i  (op_valid_0_i),
		.op_code_i   (op_code_0_i),
		.op_a_i      (op_a_0_i),
		.op_b_i      (op_b_0_i),
		.op_c_i      (op_c_0_i),
		.op_imm_i    (op_imm_0_i),
		.op_tag_i    (op_tag_0_i),
		.op_credit_o (op_credit_0_o),
		.issue_req_o (issue_req_0),
		.issue_gnt_i (gnt[0]),
		.issue_code_o(issue_code_0),
		.issue_a_o   (issue_a_0),
		.issue_b_o   (issue_b_0),
		.issue_c_o   (issue_c_0),
		.issue_imm_o (issue_imm_0),
		.issue_tag_o (issue_tag_0),
		.rb_valid_i  (rb_valid),
		.rb_data_i   (rb_data),
		.rb_tag_i    (rb_tag),
		.rb_port_i   (rb_port),
		.res_valid_o (res_valid_0_o),
		.res_data_o  (res_data_0_o),
		.res_tag_o   (res_tag_0_o),
		.res_credit_i(res_credit_0_i)
	);

	issue_port #(
		.PORT_ID(1'b1)
	) u_port1 (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.op_valid_i  (op_valid_1_i),
		.op_code_i   (op_code_1_i),
		.op_a_i      (op_a_1_i),
		.op_b_i      (op_b_1_i),
		.op_c_i      (op_c_1_i),
		.op_imm_i    (op_imm_1_i),
		.op_tag_i    (op_tag_1_i),
		.op_credit_o (op_credit_1_o),
		.issue_req_o (issue_req_1),
		.issue_gnt_i (gnt[1]),
		.issue_code_o(issue_code_1),
		.issue_a_o   (issue_a_1),
		.issue_b_o   (issue_b_1),
		.issue_c_o   (issue_c_1),
		.issue_imm_o (issue_imm_1),
		.issue_tag_o (issue_tag_1),
		.rb_valid_i  (rb_valid),
		.rb_data_i   (rb_data),
		.rb_tag_i    (rb_tag),
		.rb_port_i   (rb_port),
		.res_valid_o (res_valid_1_o),
		.res_data_o  (res_data_1_o),
		.res_tag_o   (res_tag_1_o),
		.res_credit_i(res_credit_1_i)
	);

	issue_arbiter u_arb (
		.clk    (clk),
		.rst_n_i(rst_n_i),
		.req_i  ({issue_req_1, issue_req_0}),
		.gnt_o  (gnt),
		.sel_o  (alu_sel)
	);

	// The grant vector doubles as the issue valid of the unit
	mc_alu u_alu (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.in_valid_i (gnt),
		.in_port_i  (alu_sel),
		.in_code_0_i(issue_code_0),
		.in_a_0_i   (issue_a_0),
		.in_b_0_i   (issue_b_0),
		.in_c_0_i   (issue_c_0),
		.in_imm_0_i (issue_imm_0),
		.in_tag_0_i (issue_tag_0),
		.in_code_1_i(issue_code_1),
		.in_a_1_i   (issue_a_1),
		.in_b_1_i   (issue_b_1),
		.in_c_1_i   (issue_c_1),
		.in_imm_1_i (issue_imm_1),
		.in_tag_1_i (issue_tag_1),
		.out_valid_o(rb_valid),
		.out_data_o (rb_data),
		.out_tag_o  (rb_tag),
		.out_port_o (rb_port)
	);

endmodule

// File: logic/mc_alu.sv
`timescale 1ns/10ps

module mc_alu
	import alu_op_pkg::*, alu_flow_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n_i,
	// Grant vector, one bit per port, at most one bit set
	input  logic [1:0] in_valid_i,
	// Select from the arbiter, also the owner of the operation
	input  port_id_t   in_port_i,
	// Operand set of port 0
	input  alu_op_e    in_code_0_i,
	input  value_t     in_a_0_i,
	input  value_t     in_b_0_i,
	input  value_t     in_c_0_i,
	input  value_t     in_imm_0_i,
	input  tag_t       in_tag_0_i,
	// Operand set of port 1
	input  alu_op_e    in_code_1_i,
	input  value_t     in_a_1_i,
	input  value_t     in_b_1_i,
	input  value_t     in_c_1_i,
	input  value_t     in_imm_1_i,
	input  tag_t       in_tag_1_i,
	// Shared result bus
	output logic       out_valid_o,
	output value_t     out_data_o,
	output tag_t       out_tag_o,
	output port_id_t   out_port_o
);

	// Selected operand set
	alu_op_e  code_sel;
	value_t   a_sel;
	value_t   b_sel;
	value_t   c_sel;
	value_t   imm_sel;
	tag_t     tag_sel;

	// Stage registers of the data path
	alu_op_e  code_s1;
	value_t   a_s1;
	value_t   m_s1;
	value_t   c_s1;
	alu_op_e  code_s2;
	dvalue_t  prod_s2;
	value_t   c_s2;
	alu_op_e  code_s3;
	dvalue_t  prod_s3;
	value_t   fused_s3;
	value_t   data_s4;

	// Delay line for valid, tag and owner, one entry per stage
	logic     valid_q [ALU_LAT];
	tag_t     tag_q   [ALU_LAT];
	port_id_t port_q  [ALU_LAT];

	// ==================================================
	// Operand select, driven by the arbiter
	// ==================================================

	assign code_sel = in_port_i ? in_code_1_i : in_code_0_i;
	assign a_sel    = in_port_i ? in_a_1_i    : in_a_0_i;
	assign b_sel    = in_port_i ? in_b_1_i    : in_b_0_i;
	assign c_sel    = in_port_i ? in_c_1_i    : in_c_0_i;
	assign imm_sel  = in_port_i ? in_imm_1_i  : in_imm_0_i;
	assign tag_sel  = in_port_i ? in_tag_1_i  : in_tag_0_i;

	// The data stages below are written out for a latency of four
	always_ff @(posedge clk) begin
		// Stage 1 captures the operands, the immediate replaces b for OP_MULI
		code_s1 <= code_sel;
		a_s1    <= a_sel;
		m_s1    <= (code_sel == OP_MULI) ? imm_sel : b_sel;
		c_s1    <= c_sel;

		// Stage 2 forms the full signed product
		// Both operands are signed, so they are sign extended to the product width
		code_s2 <= code_s1;
		prod_s2 <= $signed(a_s1) * $signed(m_s1);
		c_s2    <= c_s1;

		// Stage 3 applies the addend of the fused forms, wrapping at DATA_W bits
		code_s3 <= code_s2;
		prod_s3 <= prod_s2;
		case (code_s2)
			OP_MADD:  fused_s3 <= prod_s2[DATA_W-1:0] + c_s2;
			OP_MSUB:  fused_s3 <= prod_s2[DATA_W-1:0] - c_s2;
			OP_NMADD: fused_s3 <= c_s2 - prod_s2[DATA_W-1:0];
			default:  fused_s3 <= prod_s2[DATA_W-1:0];
		endcase

		// Stage 4 picks the result by opcode
		case (code_s3)
			OP_MUL, OP_MULI:          data_s4 <= prod_s3[DATA_W-1:0];
			OP_MULH:                  data_s4 <= prod_s3[2*DATA_W-1:DATA_W];
			OP_MADD, OP_MSUB, OP_NMADD: data_s4 <= fused_s3;
			default:                  data_s4 <= '0;
		endcase
	end

	// ==================================================
	// Valid, tag and owner delay line
	// ==================================================

	// Valid is control state and clears on reset
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < ALU_LAT; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else begin
			valid_q[0] <= in_valid_i[0] | in_valid_i[1];
			for (int i = 1; i < ALU_LAT; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	// Tag and owner only matter while valid is set
	always_ff @(posedge clk) begin
		tag_q[0]  <= tag_sel;
		port_q[0] <= in_port_i;
		for (int i = 1; i < ALU_LAT; i++) begin
			tag_q[i]  <= tag_q[i-1];
			port_q[i] <= port_q[i-1];
		end
	end

	assign out_valid_o = valid_q[ALU_LAT-1];
	assign out_data_o  = data_s4;
	assign out_tag_o   = tag_q[ALU_LAT-1];
	assign out_port_o  = port_q[ALU_LAT-1];

endmodule

// File: logic/issue_arbiter.sv
`timescale 1ns/10ps

module issue_arbiter
	import alu_flow_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic [1:0] req_i,
	output logic [1:0] gnt_o,
	output port_id_t   sel_o
);

	// Port that won the last granted cycle
	port_id_t last_q;
	// Port chosen in this cycle
	port_id_t win;

	// A lone requester always wins
	// With both requesting the port that lost last time goes first
	always_comb begin
		case (req_i)
			2'b01:   win = 1'b0;
			2'b10:   win = 1'b1;
			2'b11:   win = ~last_q;
			// Idle cycle, the select is not used
			default: win = last_q;
		endcase
	end

	// Grant is combinational so the port can pop in the same cycle
	assign gnt_o[0] = req_i[0] & (win == 1'b0);
	assign gnt_o[1] = req_i[1] & (win == 1'b1);

	// Steers the operand select inside the unit
	assign sel_o = win;

	// Only a real grant moves the priority
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			// Port 0 gets the first contested grant
			last_q <= 1'b1;
		end else if (req_i != 2'b00) begin
			last_q <= win;
		end
	end

endmodule

// File: logic/issue_port.sv
`timescale 1ns/10ps

module issue_port
	import alu_op_pkg::*, alu_flow_pkg::*;
#(
	parameter port_id_t PORT_ID = 1'b0
) (
	input  logic        clk,
	input  logic        rst_n_i,
	// Upstream source
	input  logic        op_valid_i,
	input  alu_op_e     op_code_i,
	input  value_t      op_a_i,
	input  value_t      op_b_i,
	input  value_t      op_c_i,
	input  value_t      op_imm_i,
	input  tag_t        op_tag_i,
	output logic        op_credit_o,
	// Request towards the arbiter and the shared unit
	output logic        issue_req_o,
	input  logic        issue_gnt_i,
	output alu_op_e     issue_code_o,
	output value_t      issue_a_o,
	output value_t      issue_b_o,
	output value_t      issue_c_o,
	output value_t      issue_imm_o,
	output tag_t        issue_tag_o,
	// Shared result bus
	input  logic        rb_valid_i,
	input  value_t      rb_data_i,
	input  tag_t        rb_tag_i,
	input  port_id_t    rb_port_i,
	// Downstream consumer
	output logic        res_valid_o,
	output value_t      res_data_o,
	output tag_t        res_tag_o,
	input  logic        res_credit_i
);

	// Queue storage, one slot per issue credit
	alu_op_e     q_code [QUEUE_DEPTH];
	value_t      q_a    [QUEUE_DEPTH];
	value_t      q_b    [QUEUE_DEPTH];
	value_t      q_c    [QUEUE_DEPTH];
	value_t      q_imm  [QUEUE_DEPTH];
	tag_t        q_tag  [QUEUE_DEPTH];

	qptr_t       wr_ptr_q;
	qptr_t       rd_ptr_q;
	credit_cnt_t fill_q;
	credit_cnt_t res_cred_q;

	logic        push;
	logic        pop;

	// Pointer step that also works for a depth that is not a power of two
	function automatic qptr_t ptr_next(qptr_t p);
		return (p == qptr_t'(QUEUE_DEPTH - 1)) ? '0 : qptr_t'(p + 1'b1);
	endfunction

	// The source only sends while it holds a credit, so a push never finds the queue full
	assign push = op_valid_i;

	// The arbiter only grants a requesting port, the AND keeps the pop safe regardless
	assign pop = issue_req_o & issue_gnt_i;

	// Issue needs an operation at the head and a free result slot downstream
	// Holding back here is what keeps every in-flight result covered by a credit
	assign issue_req_o = (fill_q != '0) && (res_cred_q != '0);

	// Head of the queue goes straight to the operand select in the unit
	assign issue_code_o = q_code[rd_ptr_q];
	assign issue_a_o    = q_a[rd_ptr_q];
	assign issue_b_o    = q_b[rd_ptr_q];
	assign issue_c_o    = q_c[rd_ptr_q];
	assign issue_imm_o  = q_imm[rd_ptr_q];
	assign issue_tag_o  = q_tag[rd_ptr_q];

	always_ff @(posedge clk) begin
		if (push) begin
			q_code[wr_ptr_q] <= op_code_i;
			q_a[wr_ptr_q]    <= op_a_i;
			q_b[wr_ptr_q]    <= op_b_i;
			q_c[wr_ptr_q]    <= op_c_i;
			q_imm[wr_ptr_q]  <= op_imm_i;
			q_tag[wr_ptr_q]  <= op_tag_i;
		end
	end

	// ==================================================
	// Pointers and credit counters
	// ==================================================

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q    <= '0;
			rd_ptr_q    <= '0;
			fill_q      <= '0;
			res_cred_q  <= credit_cnt_t'(RES_CREDITS);
			op_credit_o <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr_q <= ptr_next(wr_ptr_q);
			end
			if (pop) begin
				rd_ptr_q <= ptr_next(rd_ptr_q);
			end
			fill_q <= fill_q + credit_cnt_t'(push) - credit_cnt_t'(pop);
			// One result slot is used per issue and one comes back per consumer pulse
			res_cred_q <= res_cred_q - credit_cnt_t'(pop) + credit_cnt_t'(res_credit_i);
			// The freed queue slot is handed back to the source one cycle after issue
			op_credit_o <= pop;
		end
	end

	// Claim the results on the shared bus that carry this port's number
	// The bus is already registered in the unit, so this stays combinational
	assign res_valid_o = rb_valid_i && (rb_port_i == PORT_ID);
	assign res_data_o  = rb_data_i;
	assign res_tag_o   = rb_tag_i;

endmodule

// File: logic/alu_flow_pkg.sv
package alu_flow_pkg;

	// ==================================================
	// Identifiers carried with each operation
	// ==================================================

	// Sequence tag, returned untouched with the result
	typedef logic [2:0] tag_t;

	// Number of the issue port that owns an operation
	typedef logic port_id_t;

	// ==================================================
	// Credit and latency figures
	// ==================================================

	// Counter wide enough for every credit pool below
	typedef logic [2:0] credit_cnt_t;

	// Queue entries per port, also the source's initial issue credits
	localparam int unsigned QUEUE_DEPTH = 2;

	// Result slots the consumer of each port starts with
	localparam int unsigned RES_CREDITS = 4;

	// Cycles from an accepted grant to the result on the shared bus
	localparam int unsigned ALU_LAT = 4;

	// Queue pointer width, at least one bit
	localparam int unsigned QPTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

	typedef logic [QPTR_W-1:0] qptr_t;

endpackage

// File: logic/alu_op_pkg.sv
package alu_op_pkg;

	// ==================================================
	// Datapath widths
	// ==================================================

	// Width of every operand and every result on the result bus
	localparam int unsigned DATA_W = 32;

	// One operand or one result
	typedef logic [DATA_W-1:0] value_t;

	// Full product of two operands before the result is selected
	typedef logic [2*DATA_W-1:0] dvalue_t;

	// ==================================================
	// Operation codes
	// ==================================================

	// All operands are treated as signed two's complement values
	// The fused forms keep only the low DATA_W bits and wrap on overflow
	typedef enum logic [2:0] {
		// Low half of a*b
		OP_MUL   = 3'd0,
		// High half of the signed product a*b
		OP_MULH  = 3'd1,
		// Low half of a*imm
		OP_MULI  = 3'd2,
		// a*b + c
		OP_MADD  = 3'd3,
		// a*b - c
		OP_MSUB  = 3'd4,
		// c - a*b
		OP_NMADD = 3'd5
	} alu_op_e;

endpackage
